// File: logic/glue_defs.svh
`ifndef GLUE_DEFS_SVH
`define GLUE_DEFS_SVH

// port widths
`define GLUE_ROM_AW 15 // core side rom address
`define GLUE_IOCTL_AW 25 // download address
`define GLUE_COLOR_W 3 // per channel, after widening

// PS/2 set 2 scan codes
`define KEY_UP 8'h75
`define KEY_DOWN 8'h72
`define KEY_LEFT 8'h6B
`define KEY_RIGHT 8'h74
`define KEY_COIN 8'h76 // esc
`define KEY_START1 8'h05 // f1
`define KEY_START2 8'h06 // f2
`define KEY_FIRE1 8'h29 // space
`define KEY_FIRE2 8'h11 // alt
`define KEY_FIRE3 8'h14 // ctrl

`endif

// File: logic/glue_pkg.sv
`default_nettype none

package glue_pkg;

	// menu status word from the user io block
	typedef struct packed {
		logic [24:0] spare_hi;
		logic reset_trigger; // T6 menu entry
		logic spare_5;
		logic [1:0] scanlines; // O34
		logic rotate; // O2
		logic spare_1;
		logic reset_menu;
	} status_fields_t;

	typedef union packed {
		logic [31:0] raw;
		status_fields_t fields;
	} status_u;

endpackage

`default_nettype wire

// File: logic/key_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "glue_defs.svh"

module key_decode (
	input wire logic clock_48,
	input wire logic rst,
	input wire logic key_strobe,
	input wire logic key_pressed,
	input wire logic [7:0] key_code,
	output logic kb_up,
	output logic kb_down,
	output logic kb_left,
	output logic kb_right,
	output logic kb_coin,
	output logic kb_start1,
	output logic kb_start2,
	output logic kb_fire1,
	output logic kb_fire2,
	output logic kb_fire3
);

	logic strobe_q;
	logic key_event;

	assign key_event = key_strobe ^ strobe_q; // strobe toggles once per key event

	// tracks the strobe in reset too, so no false event on release
	always_ff @(posedge clock_48) begin
		strobe_q <= key_strobe;
	end

	always_ff @(posedge clock_48) begin
		if (rst) begin
			kb_up <= 1'b0;
			kb_down <= 1'b0;
			kb_left <= 1'b0;
			kb_right <= 1'b0;
			kb_coin <= 1'b0;
			kb_start1 <= 1'b0;
			kb_start2 <= 1'b0;
			kb_fire1 <= 1'b0;
			kb_fire2 <= 1'b0;
			kb_fire3 <= 1'b0;
		end else if (key_event) begin
			case (key_code)
				`KEY_UP: kb_up <= key_pressed;
				`KEY_DOWN: kb_down <= key_pressed;
				`KEY_LEFT: kb_left <= key_pressed;
				`KEY_RIGHT: kb_right <= key_pressed;
				`KEY_COIN: kb_coin <= key_pressed;
				`KEY_START1: kb_start1 <= key_pressed;
				`KEY_START2: kb_start2 <= key_pressed;
				`KEY_FIRE1: kb_fire1 <= key_pressed;
				`KEY_FIRE2: kb_fire2 <= key_pressed;
				`KEY_FIRE3: kb_fire3 <= key_pressed;
				default: ; // other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/control_map.sv
`timescale 1ns/100ps
`default_nettype none

module control_map import glue_pkg::*; (
	input wire logic clock_48,
	input wire logic rst,
	input wire logic kb_up,
	input wire logic kb_down,
	input wire logic kb_left,
	input wire logic kb_right,
	input wire logic kb_coin,
	input wire logic kb_start1,
	input wire logic kb_start2,
	input wire logic kb_fire1,
	input wire logic kb_fire2,
	input wire logic kb_fire3,
	input wire logic [7:0] joystick_0,
	input wire logic [7:0] joystick_1,
	input wire status_u status,
	output logic p1_up,
	output logic p1_down,
	output logic p1_left,
	output logic p1_right,
	output logic p1_fire,
	output logic p1_bomb,
	output logic p2_up,
	output logic p2_down,
	output logic p2_left,
	output logic p2_right,
	output logic p2_fire,
	output logic p2_bomb,
	output logic start1,
	output logic start2,
	output logic coin
);

	logic rot;
	logic [3:0] dir1; // {up, down, left, right}
	logic [3:0] dir2;

	// ctrl is decoded but this game has only two buttons per player
	assign rot = status.fields.rotate;
	assign dir1 = {kb_up | joystick_0[3], kb_down | joystick_0[2],
		kb_left | joystick_0[1], kb_right | joystick_0[0]};
	assign dir2 = {joystick_1[3], joystick_1[2], joystick_1[1], joystick_1[0]};

	always_ff @(posedge clock_48) begin
		if (rst) begin
			{p1_up, p1_down, p1_left, p1_right, p1_fire, p1_bomb} <= 6'b0;
			{p2_up, p2_down, p2_left, p2_right, p2_fire, p2_bomb} <= 6'b0;
			{start1, start2, coin} <= 3'b0;
		end else begin
			// rotate clear means the cabinet screen is turned
			p1_up <= rot ? dir1[3] : dir1[1];
			p1_down <= rot ? dir1[2] : dir1[0];
			p1_left <= rot ? dir1[1] : dir1[2];
			p1_right <= rot ? dir1[0] : dir1[3];
			p1_fire <= kb_fire1 | joystick_0[4];
			p1_bomb <= kb_fire2 | joystick_0[5];
			p2_up <= rot ? dir2[3] : dir2[1];
			p2_down <= rot ? dir2[2] : dir2[0];
			p2_left <= rot ? dir2[1] : dir2[2];
			p2_right <= rot ? dir2[0] : dir2[3];
			p2_fire <= joystick_1[4];
			p2_bomb <= joystick_1[5];
			start1 <= kb_start1;
			start2 <= kb_start2;
			coin <= kb_coin;
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_loader.sv
`timescale 1ns/100ps
`default_nettype none

`include "glue_defs.svh"

module rom_loader import glue_pkg::*; (
	input wire logic clock_48,
	input wire logic rst,
	input wire logic ioctl_download,
	input wire logic ioctl_wr,
	input wire logic [`GLUE_IOCTL_AW-1:0] ioctl_addr,
	input wire logic [7:0] ioctl_dout,
	input wire logic [`GLUE_ROM_AW-1:0] core_rom_addr,
	input wire logic [1:0] buttons,
	input wire status_u status,
	output logic [`GLUE_IOCTL_AW-1:0] rom_addr,
	output logic [15:0] rom_din,
	output logic rom_we,
	output logic rom_rd,
	output logic core_reset
);

	localparam int PAD_W = `GLUE_IOCTL_AW - `GLUE_ROM_AW;

	logic download_q;
	logic download_fall;
	logic rom_loaded;

	// downloader owns the port while ioctl_download is high
	assign rom_addr = ioctl_download ? ioctl_addr : {{PAD_W{1'b0}}, core_rom_addr};
	assign rom_din = {ioctl_dout, ioctl_dout}; // byte lands in both halves
	assign rom_we = ioctl_download & ioctl_wr;
	assign rom_rd = ~ioctl_download;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			download_q <= 1'b0;
			download_fall <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_q <= ioctl_download;
			download_fall <= download_q & ~ioctl_download; // registered falling edge
			if (download_fall)
				rom_loaded <= 1'b1; // sticky until system reset
			core_reset <= status.fields.reset_menu | buttons[1]
				| status.fields.reset_trigger | ~rom_loaded;
		end
	end

endmodule

`default_nettype wire

// File: logic/video_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "glue_defs.svh"

module video_out (
	input wire logic clock_48,
	input wire logic rst,
	input wire logic [`GLUE_COLOR_W-1:0] red,
	input wire logic [`GLUE_COLOR_W-1:0] green,
	input wire logic [`GLUE_COLOR_W-2:0] blue,
	input wire logic hblank,
	input wire logic vblank,
	input wire logic hsync,
	input wire logic vsync,
	output logic [`GLUE_COLOR_W-1:0] vid_r,
	output logic [`GLUE_COLOR_W-1:0] vid_g,
	output logic [`GLUE_COLOR_W-1:0] vid_b,
	output logic vid_hs,
	output logic vid_vs
);

	logic blank;
	logic [`GLUE_COLOR_W-1:0] blue_wide;

	assign blank = hblank | vblank;
	assign blue_wide = {blue, blue[0]}; // repeat lsb to reach full scale

	always_ff @(posedge clock_48) begin
		if (rst) begin
			vid_r <= '0;
			vid_g <= '0;
			vid_b <= '0;
			vid_hs <= 1'b0;
			vid_vs <= 1'b0;
		end else begin
			vid_r <= blank ? '0 : red;
			vid_g <= blank ? '0 : green;
			vid_b <= blank ? '0 : blue_wide;
			vid_hs <= hsync; // same stage as colors
			vid_vs <= vsync;
		end
	end

endmodule

`default_nettype wire

// File: logic/arcade_glue.sv
`timescale 1ns/100ps
`default_nettype none

`include "glue_defs.svh"

module arcade_glue import glue_pkg::*; (
	input wire logic clock_48,
	input wire logic rst,
	// user io
	input wire logic key_strobe,
	input wire logic key_pressed,
	input wire logic [7:0] key_code,
	input wire logic [7:0] joystick_0,
	input wire logic [7:0] joystick_1,
	input wire status_u status,
	input wire logic [1:0] buttons,
	// data io
	input wire logic ioctl_download,
	input wire logic ioctl_wr,
	input wire logic [`GLUE_IOCTL_AW-1:0] ioctl_addr,
	input wire logic [7:0] ioctl_dout,
	// game core
	input wire logic [`GLUE_ROM_AW-1:0] core_rom_addr,
	input wire logic [`GLUE_COLOR_W-1:0] red,
	input wire logic [`GLUE_COLOR_W-1:0] green,
	input wire logic [`GLUE_COLOR_W-2:0] blue,
	input wire logic hblank,
	input wire logic vblank,
	input wire logic hsync,
	input wire logic vsync,
	output logic p1_up,
	output logic p1_down,
	output logic p1_left,
	output logic p1_right,
	output logic p1_fire,
	output logic p1_bomb,
	output logic p2_up,
	output logic p2_down,
	output logic p2_left,
	output logic p2_right,
	output logic p2_fire,
	output logic p2_bomb,
	output logic start1,
	output logic start2,
	output logic coin,
	output logic core_reset,
	// sdram rom port
	output logic [`GLUE_IOCTL_AW-1:0] rom_addr,
	output logic [15:0] rom_din,
	output logic rom_we,
	output logic rom_rd,
	// to scandoubler
	output logic [`GLUE_COLOR_W-1:0] vid_r,
	output logic [`GLUE_COLOR_W-1:0] vid_g,
	output logic [`GLUE_COLOR_W-1:0] vid_b,
	output logic vid_hs,
	output logic vid_vs
);

	logic kb_up;
	logic kb_down;
	logic kb_left;
	logic kb_right;
	logic kb_coin;
	logic kb_start1;
	logic kb_start2;
	logic kb_fire1;
	logic kb_fire2;
	logic kb_fire3;

	key_decode key_decode0 (
		.clock_48(clock_48),
		.rst(rst),
		.key_strobe(key_strobe),
		.key_pressed(key_pressed),
		.key_code(key_code),
		.kb_up(kb_up),
		.kb_down(kb_down),
		.kb_left(kb_left),
		.kb_right(kb_right),
		.kb_coin(kb_coin),
		.kb_start1(kb_start1),
		.kb_start2(kb_start2),
		.kb_fire1(kb_fire1),
		.kb_fire2(kb_fire2),
		.kb_fire3(kb_fire3)
	);

	control_map control_map0 (
		.clock_48(clock_48),
		.rst(rst),
		.kb_up(kb_up),
		.kb_down(kb_down),
		.kb_left(kb_left),
		.kb_right(kb_right),
		.kb_coin(kb_coin),
		.kb_start1(kb_start1),
		.kb_start2(kb_start2),
		.kb_fire1(kb_fire1),
		.kb_fire2(kb_fire2),
		.kb_fire3(kb_fire3),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.status(status),
		.p1_up(p1_up),
		.p1_down(p1_down),
		.p1_left(p1_left),
		.p1_right(p1_right),
		.p1_fire(p1_fire),
		.p1_bomb(p1_bomb),
		.p2_up(p2_up),
		.p2_down(p2_down),
		.p2_left(p2_left),
		.p2_right(p2_right),
		.p2_fire(p2_fire),
		.p2_bomb(p2_bomb),
		.start1(start1),
		.start2(start2),
		.coin(coin)
	);

	rom_loader rom_loader0 (
		.clock_48(clock_48),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.core_rom_addr(core_rom_addr),
		.buttons(buttons),
		.status(status),
		.rom_addr(rom_addr),
		.rom_din(rom_din),
		.rom_we(rom_we),
		.rom_rd(rom_rd),
		.core_reset(core_reset)
	);

	video_out video_out0 (
		.clock_48(clock_48),
		.rst(rst),
		.red(red),
		.green(green),
		.blue(blue),
		.hblank(hblank),
		.vblank(vblank),
		.hsync(hsync),
		.vsync(vsync),
		.vid_r(vid_r),
		.vid_g(vid_g),
		.vid_b(vid_b),
		.vid_hs(vid_hs),
		.vid_vs(vid_vs)
	);

endmodule

`default_nettype wire

// File: bench/arcade_glue_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "glue_defs.svh"

module arcade_glue_tb import glue_pkg::*; ();

	logic clock_48;
	logic rst;
	logic key_strobe, key_pressed;
	logic [7:0] key_code, joystick_0, joystick_1, ioctl_dout;
	status_u status;
	logic [1:0] buttons;
	logic ioctl_download, ioctl_wr;
	logic [`GLUE_IOCTL_AW-1:0] ioctl_addr;
	logic [`GLUE_ROM_AW-1:0] core_rom_addr;
	logic [`GLUE_COLOR_W-1:0] red, green;
	logic [`GLUE_COLOR_W-2:0] blue;
	logic hblank, vblank, hsync, vsync;
	logic p1_up, p1_down, p1_left, p1_right, p1_fire, p1_bomb;
	logic p2_up, p2_down, p2_left, p2_right, p2_fire, p2_bomb;
	logic start1, start2, coin, core_reset;
	logic [`GLUE_IOCTL_AW-1:0] rom_addr;
	logic [15:0] rom_din;
	logic rom_we, rom_rd;
	logic [`GLUE_COLOR_W-1:0] vid_r, vid_g, vid_b;
	logic vid_hs, vid_vs;

	logic [14:0] ctrl_act;
	logic [9:0] kb_model; // expected button levels, same order as scan_code
	integer seed = 32'h03f5_928a;
	int pass_count;
	int fail_count;
	logic [7:0] scan_code [10] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_COIN,
		`KEY_START1, `KEY_START2, `KEY_FIRE1, `KEY_FIRE2, `KEY_FIRE3};
	string ctrl_name [15] = '{"p1_up", "p1_down", "p1_left", "p1_right", "p1_fire",
		"p1_bomb", "p2_up", "p2_down", "p2_left", "p2_right", "p2_fire", "p2_bomb",
		"start1", "start2", "coin"};

	arcade_glue dut0 (.*);

	assign ctrl_act = {p1_up, p1_down, p1_left, p1_right, p1_fire, p1_bomb,
		p2_up, p2_down, p2_left, p2_right, p2_fire, p2_bomb, start1, start2, coin};

	always #5 clock_48 = ~clock_48;

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			fail_count++;
		end else
			pass_count++;
	endtask

	task automatic check_color(input string name, input logic [`GLUE_COLOR_W-1:0] exp,
		input logic [`GLUE_COLOR_W-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			fail_count++;
		end else
			pass_count++;
	endtask

	task automatic check_addr(input string name, input logic [`GLUE_IOCTL_AW-1:0] exp,
		input logic [`GLUE_IOCTL_AW-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			fail_count++;
		end else
			pass_count++;
	endtask

	task automatic check_data(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h", name, exp, act);
			fail_count++;
		end else
			pass_count++;
	endtask

	// src and result ordered up, down, left, right
	function automatic logic [3:0] turn(input logic [3:0] src, input logic rot);
		turn = rot ? src : {src[1], src[0], src[2], src[3]};
	endfunction

	function automatic logic [14:0] expect_ctrl(input logic [9:0] kb, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot);
		logic [3:0] src1;
		src1 = {kb[0], kb[1], kb[2], kb[3]} | j0[3:0];
		expect_ctrl = {turn(src1, rot), kb[7] | j0[4], kb[8] | j0[5],
			turn(j1[3:0], rot), j1[4], j1[5], kb[5], kb[6], kb[4]};
	endfunction

	task automatic check_controls();
		logic [14:0] exp;
		exp = expect_ctrl(kb_model, joystick_0, joystick_1, status.fields.rotate);
		for (int i = 0; i < 15; i++)
			check_bit(ctrl_name[i], exp[14 - i], ctrl_act[14 - i]);
	endtask

	// edges given by the block latency, then sample mid cycle
	task automatic settle(input int cycles);
		repeat (cycles) @(posedge clock_48);
		@(negedge clock_48);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (fail_count == errs_before)
			$display("test %s done, no errors", name);
		else
			$display("test %s done, %0d errors", name, fail_count - errs_before);
	endtask

	task automatic press_key(input logic [7:0] code, input logic pressed);
		@(posedge clock_48);
		key_strobe <= ~key_strobe; // one toggle per event
		key_code <= code;
		key_pressed <= pressed;
	endtask

	task automatic set_request(input int src, input logic on);
		@(posedge clock_48);
		case (src)
			0: status.fields.reset_trigger <= on;
			1: status.fields.reset_menu <= on;
			default: buttons[1] <= on;
		endcase
	endtask

	task automatic test_reset_state();
		int errs;
		errs = fail_count;
		check_bit("core_reset", 1'b1, core_reset);
		check_controls();
		check_color("vid_r", '0, vid_r);
		check_color("vid_g", '0, vid_g);
		check_color("vid_b", '0, vid_b);
		check_bit("vid_hs", 1'b0, vid_hs);
		check_bit("vid_vs", 1'b0, vid_vs);
		report_test("reset_state", errs);
	endtask

	task automatic test_rom_download();
		int errs;
		int n;
		logic [31:0] rnd;
		logic [31:0] rnd2;
		errs = fail_count;
		@(posedge clock_48);
		ioctl_download <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			@(posedge clock_48);
			ioctl_addr <= rnd[24:0];
			ioctl_dout <= rnd2[7:0];
			ioctl_wr <= rnd2[8];
			@(negedge clock_48); // port mux is combinational
			check_addr("rom_addr", rnd[24:0], rom_addr);
			check_data("rom_din", {rnd2[7:0], rnd2[7:0]}, rom_din);
			check_bit("rom_we", rnd2[8], rom_we);
			check_bit("rom_rd", 1'b0, rom_rd);
		end
		@(posedge clock_48);
		ioctl_download <= 1'b0;
		ioctl_wr <= 1'b0;
		n = 0;
		@(negedge clock_48);
		while (core_reset !== 1'b0 && n < 20) begin
			@(negedge clock_48);
			n++;
		end
		if (core_reset !== 1'b0) begin
			$display("core_reset still high %0d cycles after the download ended", n);
			fail_count++;
		end
		rnd = $random(seed);
		@(posedge clock_48);
		core_rom_addr <= rnd[14:0];
		ioctl_wr <= 1'b1; // write strobe with no download running
		@(negedge clock_48);
		check_addr("rom_addr", {10'b0, rnd[14:0]}, rom_addr);
		check_bit("rom_rd", 1'b1, rom_rd);
		check_bit("rom_we", 1'b0, rom_we);
		@(posedge clock_48);
		ioctl_wr <= 1'b0;
		report_test("rom_download", errs);
	endtask

	task automatic test_keyboard();
		int errs;
		errs = fail_count;
		@(posedge clock_48);
		status.fields.rotate <= 1'b1; // straight mapping
		for (int i = 0; i < 10; i++) begin
			for (int p = 1; p >= 0; p--) begin
				press_key(scan_code[i], p[0]);
				kb_model[i] = p[0];
				settle(2); // decode stage then control stage
				check_controls();
			end
		end
		press_key(8'h1c, 1'b1); // not a game key
		settle(2);
		check_controls();
		report_test("keyboard", errs);
	endtask

	task automatic test_rotation();
		int errs;
		logic [31:0] rnd;
		errs = fail_count;
		for (int n = 0; n < 8; n++) begin
			for (int r = 0; r < 2; r++) begin
				rnd = $random(seed);
				@(posedge clock_48);
				joystick_0 <= rnd[7:0];
				joystick_1 <= rnd[15:8];
				status.fields.rotate <= r[0];
				settle(1);
				check_controls();
			end
		end
		@(posedge clock_48);
		joystick_0 <= 8'h00;
		joystick_1 <= 8'h00;
		settle(1);
		report_test("rotation", errs);
	endtask

	task automatic test_video();
		int errs;
		logic [31:0] rnd;
		logic blank;
		errs = fail_count;
		for (int n = 0; n < 16; n++) begin
			rnd = $random(seed);
			@(posedge clock_48);
			red <= rnd[2:0];
			green <= rnd[5:3];
			blue <= rnd[7:6];
			hblank <= rnd[8] & rnd[9];
			vblank <= rnd[10] & rnd[11];
			hsync <= rnd[12];
			vsync <= rnd[13];
			settle(1);
			blank = (rnd[8] & rnd[9]) | (rnd[10] & rnd[11]);
			check_color("vid_r", blank ? 3'b000 : rnd[2:0], vid_r);
			check_color("vid_g", blank ? 3'b000 : rnd[5:3], vid_g);
			check_color("vid_b", blank ? 3'b000 : {rnd[7:6], rnd[6]}, vid_b);
			check_bit("vid_hs", rnd[12], vid_hs);
			check_bit("vid_vs", rnd[13], vid_vs);
		end
		report_test("video", errs);
	endtask

	task automatic test_reset_requests();
		int errs;
		errs = fail_count;
		for (int s = 0; s < 3; s++) begin
			set_request(s, 1'b1);
			settle(1);
			check_bit("core_reset", 1'b1, core_reset);
			set_request(s, 1'b0);
			settle(1);
			check_bit("core_reset", 1'b0, core_reset);
		end
		report_test("reset_requests", errs);
	endtask

	initial begin
		clock_48 = 1'b0;
		pass_count = 0;
		fail_count = 0;
		kb_model = '0;
		rst <= 1'b1;
		key_strobe <= 1'b0;
		key_pressed <= 1'b0;
		key_code <= 8'h00;
		joystick_0 <= 8'h00;
		joystick_1 <= 8'h00;
		status <= '0;
		buttons <= 2'b00;
		ioctl_download <= 1'b0;
		ioctl_wr <= 1'b0;
		ioctl_addr <= '0;
		ioctl_dout <= 8'h00;
		core_rom_addr <= '0;
		red <= '0;
		green <= '0;
		blue <= '0;
		{hblank, vblank, hsync, vsync} <= 4'b0000;
		repeat (10) @(posedge clock_48);
		rst <= 1'b0;
		@(negedge clock_48);
		test_reset_state();
		test_rom_download();
		test_keyboard();
		test_rotation();
		test_video();
		test_reset_requests();
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/glue_pkg.sv
logic/key_decode.sv
logic/control_map.sv
logic/rom_loader.sv
logic/video_out.sv
logic/arcade_glue.sv
bench/arcade_glue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator; the exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module arcade_glue_tb -o arcade_glue_sim &&
./obj_dir/arcade_glue_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }
